// File: source/vga_pkg.sv
// pixel bus types for the drawing pipeline, which assumes frames narrower and shorter than 2048 counts
package vga_pkg;

    // width of the horizontal and vertical counters
    localparam int cnt_w = 11;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one pixel slot as it moves down the pipeline
    typedef struct packed {
        // pixel position within the whole frame
        logic [cnt_w-1:0] hcount;
        logic [cnt_w-1:0] vcount;
        // high outside the active area
        logic             hblnk;
        logic             vblnk;
        // active high sync pulses
        logic             hsync;
        logic             vsync;
        // colour of this slot
        rgb_t             rgb;
    } vga_bus_t;

endpackage

// File: source/axil_pkg.sv
// AXI4-Lite types for the 16-byte cursor register window with 32-bit data and no burst support
package axil_pkg;

    // bus widths
    localparam int addr_w = 4;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // stored widths of the cursor fields
    localparam int pos_w   = 11;
    localparam int color_w = 12;

    // only okay and slave error are ever returned
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // register map, word aligned
    typedef enum logic [addr_w-1:0] {
        reg_ctrl  = 4'h0,
        reg_xpos  = 4'h4,
        reg_ypos  = 4'h8,
        reg_color = 4'hc
    } reg_addr_e;

    // signals driven by the master
    typedef struct packed {
        logic [addr_w-1:0] awaddr;
        logic              awvalid;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              wvalid;
        logic              bready;
        logic [addr_w-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axil_req_t;

    // signals driven by the slave
    typedef struct packed {
        logic              awready;
        logic              wready;
        resp_e             bresp;
        logic              bvalid;
        logic              arready;
        logic [data_w-1:0] rdata;
        resp_e             rresp;
        logic              rvalid;
    } axil_rsp_t;

    // cursor settings handed to the overlay stage
    typedef struct packed {
        logic               enable;
        logic [pos_w-1:0]   xpos;
        logic [pos_w-1:0]   ypos;
        logic [color_w-1:0] color;
    } cursor_cfg_t;

endpackage

// File: source/vga_timing.sv
// frame timing with active high sync for every mode, so 1024x768 monitors need an external inverter
`timescale 1ns/1ns

module vga_timing #(
    parameter int h_active = 1024,
    parameter int h_front  = 24,
    parameter int h_sync   = 136,
    parameter int h_back   = 160,
    parameter int v_active = 768,
    parameter int v_front  = 3,
    parameter int v_sync   = 6,
    parameter int v_back   = 29
) (
    input  logic              clk,
    input  logic              rst_n,
    output vga_pkg::vga_bus_t tim_out
);

    // full line and frame lengths
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // sync window edges
    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    logic [vga_pkg::cnt_w-1:0] hcnt;
    logic [vga_pkg::cnt_w-1:0] vcnt;
    vga_pkg::vga_bus_t         tim_nxt;

    // pixel and line counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == vga_pkg::cnt_w'(h_total - 1)) begin
            hcnt <= '0;
            // new line, wrap the frame after the last one
            if (vcnt == vga_pkg::cnt_w'(v_total - 1)) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // decode blanking and sync from the current counts
    always_comb begin
        tim_nxt.hcount = hcnt;
        tim_nxt.vcount = vcnt;
        tim_nxt.hblnk  = (hcnt >= vga_pkg::cnt_w'(h_active));
        tim_nxt.vblnk  = (vcnt >= vga_pkg::cnt_w'(v_active));
        tim_nxt.hsync  = (hcnt >= vga_pkg::cnt_w'(h_sync_start))
                      && (hcnt <  vga_pkg::cnt_w'(h_sync_end));
        tim_nxt.vsync  = (vcnt >= vga_pkg::cnt_w'(v_sync_start))
                      && (vcnt <  vga_pkg::cnt_w'(v_sync_end));
        // colour is filled in by later stages
        tim_nxt.rgb    = '0;
    end

    // registered output, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tim_out <= '0;
        end else begin
            tim_out <= tim_nxt;
        end
    end

endmodule

// File: source/draw_bg.sv
// background stage with one cycle of latency that expects counts already aligned to the active area
`timescale 1ns/1ns

module draw_bg #(
    parameter int h_active = 1024,
    parameter int v_active = 768
) (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::vga_bus_t bg_in,
    output vga_pkg::vga_bus_t bg_out
);

    // last active column and row
    localparam int h_last = h_active - 1;
    localparam int v_last = v_active - 1;

    vga_pkg::rgb_t rgb_nxt;
    logic          on_border;

    // one pixel frame around the active area
    assign on_border = (bg_in.hcount == '0)
                    || (bg_in.vcount == '0)
                    || (bg_in.hcount == vga_pkg::cnt_w'(h_last))
                    || (bg_in.vcount == vga_pkg::cnt_w'(v_last));

    always_comb begin
        if (bg_in.hblnk || bg_in.vblnk) begin
            // nothing is shown while blanked
            rgb_nxt = '0;
        end else if (on_border) begin
            rgb_nxt = 12'hfff;
        end else begin
            // gradient repeats every 16 pixels
            rgb_nxt.r = bg_in.hcount[3:0];
            rgb_nxt.g = bg_in.vcount[3:0];
            rgb_nxt.b = 4'h8;
        end
    end

    // timing fields move along with the new colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bg_out <= '0;
        end else begin
            bg_out.hcount <= bg_in.hcount;
            bg_out.vcount <= bg_in.vcount;
            bg_out.hblnk  <= bg_in.hblnk;
            bg_out.vblnk  <= bg_in.vblnk;
            bg_out.hsync  <= bg_in.hsync;
            bg_out.vsync  <= bg_in.vsync;
            bg_out.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: source/cursor_regs.sv
// AXI4-Lite slave that takes one write and one read at a time and expects AW and W to arrive together
`timescale 1ns/1ns

module cursor_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axil_pkg::axil_req_t    axil_req,
    output axil_pkg::axil_rsp_t    axil_rsp,
    output axil_pkg::cursor_cfg_t  cursor_cfg
);

    // stored register fields
    logic                         ctrl_en;
    logic [axil_pkg::pos_w-1:0]   xpos;
    logic [axil_pkg::pos_w-1:0]   ypos;
    logic [axil_pkg::color_w-1:0] color;

    // write channel state
    logic                         wr_ready;
    logic                         wr_fire;
    logic                         bvalid;
    axil_pkg::resp_e              bresp;

    // read channel state
    logic                         rd_ready;
    logic                         rd_fire;
    logic                         rvalid;
    axil_pkg::resp_e              rresp;
    logic [axil_pkg::data_w-1:0]  rdata;
    logic [axil_pkg::data_w-1:0]  rd_value;
    logic                         rd_err;

    // merge new bytes into an old word per strobe bit
    function automatic logic [axil_pkg::data_w-1:0] merge_strb(
        input logic [axil_pkg::data_w-1:0] old_val,
        input logic [axil_pkg::data_w-1:0] new_val,
        input logic [axil_pkg::strb_w-1:0] strb
    );
        logic [axil_pkg::data_w-1:0] res;
        for (int i = 0; i < axil_pkg::strb_w; i++) begin
            res[i*8 +: 8] = strb[i] ? new_val[i*8 +: 8] : old_val[i*8 +: 8];
        end
        return res;
    endfunction

    // handshakes complete when ready meets a held valid
    assign wr_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = rd_ready && axil_req.arvalid;

    // write engine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            ctrl_en  <= 1'b0;
            xpos     <= '0;
            ypos     <= '0;
            color    <= '0;
        end else begin
            // one cycle ready pulse only when no response is pending
            wr_ready <= !wr_ready && !bvalid && axil_req.awvalid && axil_req.wvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                // stored width masks the upper bits
                case (axil_pkg::reg_addr_e'(axil_req.awaddr))
                    axil_pkg::reg_ctrl: begin
                        ctrl_en <= 1'(merge_strb(32'(ctrl_en), axil_req.wdata,
                                                 axil_req.wstrb));
                    end
                    axil_pkg::reg_xpos: begin
                        xpos <= axil_pkg::pos_w'(merge_strb(32'(xpos), axil_req.wdata,
                                                            axil_req.wstrb));
                    end
                    axil_pkg::reg_ypos: begin
                        ypos <= axil_pkg::pos_w'(merge_strb(32'(ypos), axil_req.wdata,
                                                            axil_req.wstrb));
                    end
                    axil_pkg::reg_color: begin
                        color <= axil_pkg::color_w'(merge_strb(32'(color), axil_req.wdata,
                                                               axil_req.wstrb));
                    end
                    default: begin
                        // unmapped address changes nothing
                    end
                endcase
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // write response code held with bvalid
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            case (axil_pkg::reg_addr_e'(axil_req.awaddr))
                axil_pkg::reg_ctrl, axil_pkg::reg_xpos,
                axil_pkg::reg_ypos, axil_pkg::reg_color: bresp <= axil_pkg::resp_okay;
                default:                                 bresp <= axil_pkg::resp_slverr;
            endcase
        end
    end

    // read mux with unused bits at zero
    always_comb begin
        rd_value = '0;
        rd_err   = 1'b0;
        case (axil_pkg::reg_addr_e'(axil_req.araddr))
            axil_pkg::reg_ctrl:  rd_value[0] = ctrl_en;
            axil_pkg::reg_xpos:  rd_value[axil_pkg::pos_w-1:0] = xpos;
            axil_pkg::reg_ypos:  rd_value[axil_pkg::pos_w-1:0] = ypos;
            axil_pkg::reg_color: rd_value[axil_pkg::color_w-1:0] = color;
            default:             rd_err = 1'b1;
        endcase
    end

    // read engine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_ready <= !rd_ready && !rvalid && axil_req.arvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read payload held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_value;
            rresp <= rd_err ? axil_pkg::resp_slverr : axil_pkg::resp_okay;
        end
    end

    // slave outputs
    assign axil_rsp.awready = wr_ready;
    assign axil_rsp.wready  = wr_ready;
    assign axil_rsp.bresp   = bresp;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.arready = rd_ready;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = rresp;
    assign axil_rsp.rvalid  = rvalid;

    // live settings that the overlay samples once per frame
    assign cursor_cfg.enable = ctrl_en;
    assign cursor_cfg.xpos   = xpos;
    assign cursor_cfg.ypos   = ypos;
    assign cursor_cfg.color  = color;

endmodule

// File: source/draw_cursor.sv
// square cursor overlay whose settings change only at frame start and which is clipped by blanking
`timescale 1ns/1ns

module draw_cursor #(
    parameter int cursor_size = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axil_pkg::cursor_cfg_t cursor_cfg,
    input  vga_pkg::vga_bus_t     dcur_in,
    output vga_pkg::vga_bus_t     dcur_out
);

    axil_pkg::cursor_cfg_t shadow;
    axil_pkg::cursor_cfg_t cfg_eff;
    logic                  frame_start;
    logic [11:0]           x_end;
    logic [11:0]           y_end;
    logic                  in_x;
    logic                  in_y;
    logic                  hit;

    // first pixel of a frame
    assign frame_start = (dcur_in.hcount == '0) && (dcur_in.vcount == '0);

    // pixel 0,0 already uses the fresh settings
    assign cfg_eff = frame_start ? cursor_cfg : shadow;

    // frame shadow of the settings
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow <= '0;
        end else if (frame_start) begin
            shadow <= cursor_cfg;
        end
    end

    // one extra bit so the end never wraps
    assign x_end = {1'b0, cfg_eff.xpos} + 12'(cursor_size);
    assign y_end = {1'b0, cfg_eff.ypos} + 12'(cursor_size);

    assign in_x = (dcur_in.hcount >= cfg_eff.xpos) && ({1'b0, dcur_in.hcount} < x_end);
    assign in_y = (dcur_in.vcount >= cfg_eff.ypos) && ({1'b0, dcur_in.vcount} < y_end);

    // blanking clips the square at the right and bottom edges
    assign hit = cfg_eff.enable && in_x && in_y && !dcur_in.hblnk && !dcur_in.vblnk;

    // output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dcur_out <= '0;
        end else begin
            dcur_out.hcount <= dcur_in.hcount;
            dcur_out.vcount <= dcur_in.vcount;
            dcur_out.hblnk  <= dcur_in.hblnk;
            dcur_out.vblnk  <= dcur_in.vblnk;
            dcur_out.hsync  <= dcur_in.hsync;
            dcur_out.vsync  <= dcur_in.vsync;
            // cursor colour replaces the background
            if (hit) begin
                dcur_out.rgb <= cfg_eff.color;
            end else begin
                dcur_out.rgb <= dcur_in.rgb;
            end
        end
    end

endmodule

// File: source/vga_top.sv
// VGA top on one clock with three pixels of latency and active high sync that some monitors must invert
`timescale 1ns/1ns

module vga_top #(
    parameter int h_active    = 1024,
    parameter int h_front     = 24,
    parameter int h_sync      = 136,
    parameter int h_back      = 160,
    parameter int v_active    = 768,
    parameter int v_front     = 3,
    parameter int v_sync      = 6,
    parameter int v_back      = 29,
    parameter int cursor_size = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output logic                hsync,
    output logic                vsync,
    output logic [11:0]         rgb
);

    // pipeline buses
    vga_pkg::vga_bus_t     tim_bus;
    vga_pkg::vga_bus_t     bg_bus;
    vga_pkg::vga_bus_t     out_bus;

    // host settings for the overlay
    axil_pkg::cursor_cfg_t cursor_cfg;

    // pin mapping from the last stage
    assign hsync = out_bus.hsync;
    assign vsync = out_bus.vsync;
    assign rgb   = out_bus.rgb;

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) u_vga_timing (
        .clk,
        .rst_n,
        .tim_out (tim_bus)
    );

    draw_bg #(
        .h_active (h_active),
        .v_active (v_active)
    ) u_draw_bg (
        .clk,
        .rst_n,
        .bg_in  (tim_bus),
        .bg_out (bg_bus)
    );

    // register block on the host bus
    cursor_regs u_cursor_regs (
        .clk,
        .rst_n,
        .axil_req,
        .axil_rsp,
        .cursor_cfg
    );

    draw_cursor #(
        .cursor_size (cursor_size)
    ) u_draw_cursor (
        .clk,
        .rst_n,
        .cursor_cfg,
        .dcur_in  (bg_bus),
        .dcur_out (out_bus)
    );

endmodule

// File: verification/vga_top_checker.sv
// bound to vga_top and assumes a single clock with sync_len set to the horizontal sync width
`timescale 1ns/1ns

module vga_top_checker #(
    parameter int sync_len = 3
) (
    input logic                clk,
    input logic                rst_n,
    input axil_pkg::axil_req_t axil_req,
    input axil_pkg::axil_rsp_t axil_rsp,
    input logic                hsync,
    input logic                vsync
);

    // length of the current hsync pulse
    logic [11:0] hsync_len;

    // number of failed assertions so far
    int          fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_len <= '0;
        end else if (hsync) begin
            hsync_len <= hsync_len + 1'b1;
        end else begin
            hsync_len <= '0;
        end
    end

    // write response waits for bready
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else begin
            fail_count++;
            $error("bvalid or bresp changed before bready");
        end

    // read data frozen under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready
        |=> axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
        else begin
            fail_count++;
            $error("rvalid or rdata changed before rready");
        end

    // syncs quiet in reset
    assert property (@(posedge clk) !rst_n |=> !hsync && !vsync)
        else begin
            fail_count++;
            $error("sync active during reset");
        end

    // pulse width at the falling edge
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hsync) |-> hsync_len == 12'(sync_len))
        else begin
            fail_count++;
            $error("hsync pulse has the wrong width");
        end

endmodule

bind vga_top vga_top_checker #(.sync_len(h_sync)) chk_i (
    .clk,
    .rst_n,
    .axil_req,
    .axil_rsp,
    .hsync,
    .vsync
);

// File: verification/vga_top_tb.sv
// runs the 32x24 test mode only and expects the first output pixel three cycles after reset release
`timescale 1ns/1ns

module vga_top_tb;

    // small test mode so that a frame is only 40x32 clocks
    localparam int h_active    = 32;
    localparam int h_front     = 2;
    localparam int h_sync      = 3;
    localparam int h_back      = 3;
    localparam int v_active    = 24;
    localparam int v_front     = 2;
    localparam int v_sync      = 3;
    localparam int v_back      = 3;
    localparam int cursor_size = 4;
    localparam int h_total      = h_active + h_front + h_sync + h_back;
    localparam int v_total      = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles = h_total * v_total;
    localparam int bus_timeout  = 20;

    // expected outputs for one pixel slot
    typedef struct packed {
        logic        hsync;
        logic        vsync;
        logic [11:0] rgb;
    } pix_t;

    logic                  clk;
    logic                  rst_n;
    axil_pkg::axil_req_t   axil_req;
    axil_pkg::axil_rsp_t   axil_rsp;
    logic                  hsync;
    logic                  vsync;
    logic [11:0]           rgb;

    // register contents as the host has written them
    axil_pkg::cursor_cfg_t model_cfg;
    int                    mismatch_errors = 0;
    int                    timeout_errors  = 0;

    vga_top #(
        .h_active    (h_active),
        .h_front     (h_front),
        .h_sync      (h_sync),
        .h_back      (h_back),
        .v_active    (v_active),
        .v_front     (v_front),
        .v_sync      (v_sync),
        .v_back      (v_back),
        .cursor_size (cursor_size)
    ) dut_i (
        .clk,
        .rst_n,
        .axil_req,
        .axil_rsp,
        .hsync,
        .vsync,
        .rgb
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        int assert_errors;
        assert_errors = dut_i.chk_i.fail_count;
        $display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_errors, timeout_errors, assert_errors);
        if (mismatch_errors == 0 && timeout_errors == 0 && assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        timeout_errors++;
        $display("ERROR at %0t: timed out, %s", $time, what);
        finish_run();
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual,
                     expected);
        end
    endtask

    // expected pixel from the drawing rules
    function automatic pix_t ref_pixel(input int h, input int v,
                                       input axil_pkg::cursor_cfg_t cfg);
        pix_t p;
        int   cx;
        int   cy;
        cx = int'(cfg.xpos);
        cy = int'(cfg.ypos);
        p.hsync = (h >= h_active + h_front) && (h < h_active + h_front + h_sync);
        p.vsync = (v >= v_active + v_front) && (v < v_active + v_front + v_sync);
        if (h >= h_active || v >= v_active) begin
            p.rgb = 12'h000;
        end else if (cfg.enable && h >= cx && h < cx + cursor_size
                     && v >= cy && v < cy + cursor_size) begin
            p.rgb = cfg.color;
        end else if (h == 0 || v == 0 || h == h_active - 1 || v == v_active - 1) begin
            p.rgb = 12'hfff;
        end else begin
            // red follows the column and green the row
            p.rgb = {4'(h % 16), 4'(v % 16), 4'h8};
        end
        return p;
    endfunction

    function automatic logic expected_slverr(input logic [3:0] addr);
        return !(addr == 4'h0 || addr == 4'h4 || addr == 4'h8 || addr == 4'hc);
    endfunction

    // readback word of the model with unused bits zero
    function automatic logic [31:0] model_read(input logic [3:0] addr);
        case (addr)
            4'h0:    return {31'd0, model_cfg.enable};
            4'h4:    return {21'd0, model_cfg.xpos};
            4'h8:    return {21'd0, model_cfg.ypos};
            4'hc:    return {20'd0, model_cfg.color};
            default: return 32'd0;
        endcase
    endfunction

    // byte lanes picked by the strobes and cut to the field width
    function automatic void model_write(input logic [3:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic [31:0] lanes;
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            lanes[b*8 +: 8] = {8{strb[b]}};
        end
        word = (model_read(addr) & ~lanes) | (data & lanes);
        case (addr)
            4'h0:    model_cfg.enable = word[0];
            4'h4:    model_cfg.xpos   = word[10:0];
            4'h8:    model_cfg.ypos   = word[10:0];
            4'hc:    model_cfg.color  = word[11:0];
            default: ;
        endcase
    endfunction

    // stall is the number of cycles bready stays low once bvalid is up
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int stall,
                              output logic [1:0] resp);
        int n;
        int i;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > bus_timeout) timeout_fail("awready never rose");
        end while (!axil_rsp.awready);
        check(32'(axil_rsp.wready), 32'd1, "wready together with awready");
        // transfer completes on this edge
        @(posedge clk);
        model_write(addr, data, strb);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
            n++;
            if (n > bus_timeout) timeout_fail("bvalid never rose");
        end
        resp = axil_rsp.bresp;
        for (i = 0; i < stall; i++) begin
            @(negedge clk);
            check(32'(axil_rsp.bvalid), 32'd1, "bvalid held while bready low");
            check(32'(axil_rsp.bresp), 32'(resp), "bresp held while bready low");
        end
        axil_req.bready = 1'b1;
        @(negedge clk);
        check(32'(axil_rsp.bvalid), 32'd0, "bvalid cleared after bready");
    endtask

    task automatic axil_read(input logic [3:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        int n;
        int i;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > bus_timeout) timeout_fail("arready never rose");
        end while (!axil_rsp.arready);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
            n++;
            if (n > bus_timeout) timeout_fail("rvalid never rose");
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        for (i = 0; i < stall; i++) begin
            @(negedge clk);
            check(32'(axil_rsp.rvalid), 32'd1, "rvalid held while rready low");
            check(axil_rsp.rdata, data, "rdata held while rready low");
        end
        axil_req.rready = 1'b1;
        @(negedge clk);
        check(32'(axil_rsp.rvalid), 32'd0, "rvalid cleared after rready");
    endtask

    task automatic write_check(input logic [3:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int stall);
        logic [1:0] resp;
        axil_write(addr, data, strb, stall, resp);
        check(32'(resp), expected_slverr(addr) ? 32'h2 : 32'h0, "write response code");
    endtask

    task automatic read_check(input logic [3:0] addr, input int stall);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, stall, data, resp);
        check(32'(resp), expected_slverr(addr) ? 32'h2 : 32'h0, "read response code");
        check(data, model_read(addr), $sformatf("readback of address %h", addr));
    endtask

    // counts rising edges of vsync or hsync at the pins
    task automatic wait_sync_rises(input logic on_vsync, input int count);
        int   seen;
        int   n;
        logic prev;
        logic cur;
        seen = 0;
        n    = 0;
        prev = on_vsync ? vsync : hsync;
        while (seen < count) begin
            @(negedge clk);
            n++;
            cur = on_vsync ? vsync : hsync;
            if (cur && !prev) seen++;
            prev = cur;
            if (n > (count + 1) * frame_cycles) timeout_fail("sync pulses stopped");
        end
    endtask

    // compares every output pixel with the model
    initial begin : compare_proc
        int                    hc;
        int                    vc;
        int                    n;
        axil_pkg::cursor_cfg_t frame_cfg;
        pix_t                  exp_pix;
        hc = 0;
        vc = 0;
        n  = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 100) timeout_fail("reset was never released");
        end while (!rst_n);
        @(posedge clk);
        // settings sampled just before pixel 0,0 reaches the overlay
        @(negedge clk);
        frame_cfg = model_cfg;
        forever begin
            @(negedge clk);
            exp_pix = ref_pixel(hc, vc, frame_cfg);
            check({18'd0, hsync, vsync, rgb}, {18'd0, exp_pix},
                  $sformatf("pixel at %0d,%0d", hc, vc));
            hc++;
            if (hc == h_total) begin
                hc = 0;
                vc = (vc + 1) % v_total;
            end
            if (hc == 0 && vc == 0) frame_cfg = model_cfg;
        end
    end

    initial begin : main_proc
        logic [31:0] x;
        logic [31:0] y;
        logic [3:0]  addr;
        void'($urandom(32'hbe0e_466c));
        axil_req        = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        model_cfg       = '0;
        rst_n           = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // background only for two frames
        wait_sync_rises(1'b1, 2);

        // full writes and masked readback
        write_check(axil_pkg::reg_ctrl, 32'hffff_fffe, 4'hf, 0);
        write_check(axil_pkg::reg_xpos, 32'hdead_beef, 4'hf, 0);
        write_check(axil_pkg::reg_ypos, 32'h0bad_f00d, 4'hf, 0);
        write_check(axil_pkg::reg_color, 32'h1234_5abc, 4'hf, 0);
        for (int i = 0; i < 16; i += 4) read_check(4'(i), 0);
        // partial strobes touch single bytes
        write_check(axil_pkg::reg_xpos, 32'hffff_ff05, 4'b0010, 0);
        write_check(axil_pkg::reg_color, 32'h0000_00ff, 4'b0001, 0);
        read_check(axil_pkg::reg_xpos, 0);
        read_check(axil_pkg::reg_color, 0);

        // unmapped addresses
        write_check(4'h2, 32'hffff_ffff, 4'hf, 0);
        write_check(4'h7, 32'h0000_0001, 4'hf, 0);
        read_check(4'h6, 0);
        for (int i = 0; i < 16; i += 4) read_check(4'(i), 0);

        // random cursors and one clipped at the bottom right corner
        for (int k = 0; k < 5; k++) begin
            x = (k == 4) ? 32'(h_active - 2) : $urandom % h_active;
            y = (k == 4) ? 32'(v_active - 1) : $urandom % v_active;
            write_check(axil_pkg::reg_xpos, x, 4'hf, 0);
            write_check(axil_pkg::reg_ypos, y, 4'hf, 0);
            write_check(axil_pkg::reg_color, $urandom, 4'hf, 0);
            write_check(axil_pkg::reg_ctrl, 32'h1, 4'hf, 0);
            wait_sync_rises(1'b1, 2);
        end

        // move the cursor while line 11 is on screen
        wait_sync_rises(1'b1, 1);
        wait_sync_rises(1'b0, 18);
        write_check(axil_pkg::reg_xpos, 32'd5, 4'hf, 0);
        write_check(axil_pkg::reg_ypos, 32'd3, 4'hf, 0);
        wait_sync_rises(1'b1, 2);

        // stalled responses
        for (int k = 0; k < 8; k++) begin
            addr = 4'(($urandom % 4) * 4);
            write_check(addr, $urandom, 4'hf, 1 + int'($urandom % 6));
            read_check(addr, 1 + int'($urandom % 6));
        end
        for (int i = 0; i < 16; i += 4) read_check(4'(i), int'($urandom % 4));
        wait_sync_rises(1'b1, 2);

        finish_run();
    end

endmodule

// File: vga_top.f
source/vga_pkg.sv
source/axil_pkg.sv
source/vga_timing.sv
source/draw_bg.sv
source/cursor_regs.sv
source/draw_cursor.sv
source/vga_top.sv
verification/vga_top_checker.sv
verification/vga_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the VGA testbench
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module vga_top_tb -f vga_top.f -o vga_top_sim

status=0
./obj_dir/vga_top_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
